/* rtl/l1d_miss_pkg.sv */
`default_nettype none

package l1d_miss_pkg;

  // ----------------------------------------------------------------------
  // Address and line geometry
  // ----------------------------------------------------------------------
  localparam int PADDR_W     = 32;
  localparam int LINE_BYTES  = 16;
  localparam int LINE_OFS_W  = $clog2(LINE_BYTES);
  localparam int LINE_ADDR_W = PADDR_W - LINE_OFS_W;

  // Writeback payload, one full line
  localparam int LINE_DATA_W = 128;

  // ----------------------------------------------------------------------
  // Queue sizes
  // ----------------------------------------------------------------------
  localparam int LSU_PORT_NUM = 2;

  localparam int LRQ_ENTRIES = 4;
  localparam int LRQ_IDX_W   = $clog2(LRQ_ENTRIES);

  localparam int EVB_ENTRIES = 2;
  localparam int EVB_IDX_W   = $clog2(EVB_ENTRIES);

  // L2 tag is {source, entry index}, index zero-extended
  localparam int L2_TAG_W = 4;

  // ----------------------------------------------------------------------
  // L2 request encodings
  // ----------------------------------------------------------------------
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } l2_cmd_e;

  // Top bit of the L2 tag
  typedef enum logic {
    SRC_LOAD  = 1'b0,
    SRC_EVICT = 1'b1
  } l2_src_e;

  // ----------------------------------------------------------------------
  // Miss queue entry
  // ----------------------------------------------------------------------
  // sent is set once the read has left on the L2 bus;
  // valid stays up until the refill comes back
  typedef struct packed {
    logic                   valid;
    logic                   sent;
    logic [LINE_ADDR_W-1:0] line;
  } lrq_entry_t;

endpackage

`default_nettype wire

/* rtl/l1d_miss_port_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface l1d_miss_port_if
  import l1d_miss_pkg::*;
();

  // Miss report from the pipeline
  logic                   valid;
  logic [PADDR_W-1:0]     paddr;

  // Same-cycle reply from the queue
  logic                   full;
  logic                   conflict;
  logic [LRQ_ENTRIES-1:0] hit_index_oh;

  modport requester (
    output valid,
    output paddr,
    input  full,
    input  conflict,
    input  hit_index_oh
  );

  modport queue (
    input  valid,
    input  paddr,
    output full,
    output conflict,
    output hit_index_oh
  );

endinterface

`default_nettype wire

/* rtl/l2_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface l2_req_if
  import l1d_miss_pkg::*;
();

  logic                   valid;
  logic                   ready;
  l2_cmd_e                cmd;
  logic [PADDR_W-1:0]     addr;
  logic [L2_TAG_W-1:0]    tag;
  logic [LINE_DATA_W-1:0] data;

  // Payload holds while valid is up and ready is low
  modport requester (
    output valid,
    input  ready,
    output cmd,
    output addr,
    output tag,
    output data
  );

  modport arbiter (
    input  valid,
    output ready,
    input  cmd,
    input  addr,
    input  tag,
    input  data
  );

endinterface

`default_nettype wire

/* rtl/l1d_load_requester.sv */
`timescale 1ns/100ps
`default_nettype none

module l1d_load_requester
  import l1d_miss_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  l1d_miss_port_if.queue         ld_port [LSU_PORT_NUM],
  l1d_miss_port_if.queue         stq_port,
  l2_req_if.requester            l2_req,
  input  logic                   i_resp_valid,
  input  logic [L2_TAG_W-1:0]    i_resp_tag,
  output logic                   o_resolve_valid,
  output logic [LRQ_ENTRIES-1:0] o_resolve_index_oh
);

  lrq_entry_t              r_entries [LRQ_ENTRIES];
  logic [LRQ_IDX_W-1:0]    r_wr_ptr;
  logic [LRQ_IDX_W-1:0]    r_rd_ptr;
  logic [LRQ_ENTRIES-1:0]  w_valid_vec;

  logic [LINE_ADDR_W-1:0]  w_ld_line [LSU_PORT_NUM];
  logic [LRQ_ENTRIES-1:0]  w_ld_hit [LSU_PORT_NUM];
  logic [LSU_PORT_NUM-1:0] w_port_hit;
  logic [LSU_PORT_NUM-1:0] w_ld_req;
  logic [LSU_PORT_NUM-1:0] w_ld_alloc;
  logic [LRQ_IDX_W-1:0]    w_ld_tgt [LSU_PORT_NUM];
  logic [LRQ_IDX_W-1:0]    w_ld_cnt;

  logic [LINE_ADDR_W-1:0]  w_stq_line;
  logic [LRQ_ENTRIES-1:0]  w_stq_hit;
  logic                    w_stq_alloc;

  logic [LRQ_ENTRIES-1:0]  w_wr_en;
  logic [LINE_ADDR_W-1:0]  w_wr_line [LRQ_ENTRIES];

  logic                    w_issue;
  logic                    w_release;
  logic [LRQ_IDX_W-1:0]    w_rel_idx;

  for (genvar b = 0; b < LRQ_ENTRIES; b++) begin : g_vld
    assign w_valid_vec[b] = r_entries[b].valid;
  end

  // ----------------------------------------------------------------------
  // Load ports: compare against entries and lower-numbered ports
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < LSU_PORT_NUM; p++) begin : g_port
    logic [LSU_PORT_NUM-1:0] w_same_line;

    assign w_ld_line[p] = ld_port[p].paddr[PADDR_W-1:LINE_OFS_W];

    for (genvar b = 0; b < LRQ_ENTRIES; b++) begin : g_ent
      assign w_ld_hit[p][b] = ld_port[p].valid & r_entries[b].valid &
                              (r_entries[b].line == w_ld_line[p]);
    end

    for (genvar q = 0; q < LSU_PORT_NUM; q++) begin : g_lower
      if (q < p) begin : g_cmp
        assign w_same_line[q] = ld_port[q].valid & (w_ld_line[q] == w_ld_line[p]);
      end else begin : g_none
        assign w_same_line[q] = 1'b0;
      end
    end

    // A line already reported by a lower port is dropped without a flag
    assign w_port_hit[p] = ld_port[p].valid & (|w_same_line);
    assign w_ld_req[p]   = ld_port[p].valid & ~(|w_ld_hit[p]) & ~w_port_hit[p];

    assign ld_port[p].conflict     = |w_ld_hit[p];
    assign ld_port[p].hit_index_oh = w_ld_hit[p];
    // Full when the slot this port would take is still busy
    assign ld_port[p].full         = w_valid_vec[w_ld_tgt[p]] & ~w_port_hit[p];
  end

  // Slots are handed out from the write pointer in port order
  always_comb begin
    w_ld_cnt = '0;
    for (int p = 0; p < LSU_PORT_NUM; p++) begin
      w_ld_tgt[p]   = r_wr_ptr + w_ld_cnt;
      w_ld_alloc[p] = w_ld_req[p] & ~w_valid_vec[w_ld_tgt[p]];
      w_ld_cnt      = w_ld_cnt + LRQ_IDX_W'(w_ld_alloc[p]);
    end
  end

  // ----------------------------------------------------------------------
  // Store-queue port, lowest priority
  // ----------------------------------------------------------------------
  assign w_stq_line = stq_port.paddr[PADDR_W-1:LINE_OFS_W];

  for (genvar b = 0; b < LRQ_ENTRIES; b++) begin : g_stq_ent
    assign w_stq_hit[b] = stq_port.valid & r_entries[b].valid &
                          (r_entries[b].line == w_stq_line);
  end

  assign stq_port.conflict     = |w_stq_hit;
  assign stq_port.hit_index_oh = w_stq_hit;
  assign stq_port.full         = w_valid_vec[r_wr_ptr];

  assign w_stq_alloc = stq_port.valid & ~(|w_stq_hit) & ~w_valid_vec[r_wr_ptr] &
                       ~(|w_ld_alloc);

  always_comb begin
    w_wr_en = '0;
    for (int b = 0; b < LRQ_ENTRIES; b++) begin
      w_wr_line[b] = w_stq_line;
    end
    if (w_stq_alloc) begin
      w_wr_en[r_wr_ptr] = 1'b1;
    end
    for (int p = 0; p < LSU_PORT_NUM; p++) begin
      if (w_ld_alloc[p]) begin
        w_wr_en[w_ld_tgt[p]]   = 1'b1;
        w_wr_line[w_ld_tgt[p]] = w_ld_line[p];
      end
    end
  end

  // ----------------------------------------------------------------------
  // In-order read issue and refill release
  // ----------------------------------------------------------------------
  assign l2_req.valid = r_entries[r_rd_ptr].valid & ~r_entries[r_rd_ptr].sent;
  assign l2_req.cmd   = CMD_READ;
  assign l2_req.addr  = {r_entries[r_rd_ptr].line, {LINE_OFS_W{1'b0}}};
  assign l2_req.tag   = {SRC_LOAD, (L2_TAG_W-1)'(r_rd_ptr)};
  assign l2_req.data  = '0;

  assign w_issue   = l2_req.valid & l2_req.ready;
  assign w_release = i_resp_valid & (i_resp_tag[L2_TAG_W-1] == SRC_LOAD);
  assign w_rel_idx = i_resp_tag[LRQ_IDX_W-1:0];

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      for (int b = 0; b < LRQ_ENTRIES; b++) begin
        r_entries[b] <= '0;
      end
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      for (int b = 0; b < LRQ_ENTRIES; b++) begin
        if (w_wr_en[b]) begin
          r_entries[b].valid <= 1'b1;
          r_entries[b].sent  <= 1'b0;
          r_entries[b].line  <= w_wr_line[b];
        end else begin
          if (w_issue && (r_rd_ptr == LRQ_IDX_W'(b))) begin
            r_entries[b].sent <= 1'b1;
          end
          if (w_release && (w_rel_idx == LRQ_IDX_W'(b))) begin
            r_entries[b].valid <= 1'b0;
          end
        end
      end
      r_wr_ptr <= r_wr_ptr + w_ld_cnt + LRQ_IDX_W'(w_stq_alloc);
      if (w_issue) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
    end
  end

  // Resolve notice to the load queue, one cycle after the refill
  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      o_resolve_valid    <= 1'b0;
      o_resolve_index_oh <= '0;
    end else begin
      o_resolve_valid    <= w_release;
      o_resolve_index_oh <= w_release ? (LRQ_ENTRIES'(1) << w_rel_idx) : '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/l1d_evict_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module l1d_evict_buffer
  import l1d_miss_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_evict_valid,
  input  logic [PADDR_W-1:0]     i_evict_paddr,
  input  logic [LINE_DATA_W-1:0] i_evict_data,
  output logic                   o_evict_ready,
  l2_req_if.requester            l2_req
);

  logic [EVB_ENTRIES-1:0] r_vld;
  logic [EVB_IDX_W-1:0]   r_wr_ptr;
  logic [EVB_IDX_W-1:0]   r_rd_ptr;
  logic [LINE_ADDR_W-1:0] r_line [EVB_ENTRIES];
  logic [LINE_DATA_W-1:0] r_data [EVB_ENTRIES];

  logic                   w_accept;
  logic                   w_sent;

  // Accept while the slot under the write pointer is free
  assign o_evict_ready = ~r_vld[r_wr_ptr];
  assign w_accept      = i_evict_valid & o_evict_ready;

  // ----------------------------------------------------------------------
  // Write requests from the oldest slot
  // ----------------------------------------------------------------------
  assign l2_req.valid = r_vld[r_rd_ptr];
  assign l2_req.cmd   = CMD_WRITE;
  assign l2_req.addr  = {r_line[r_rd_ptr], {LINE_OFS_W{1'b0}}};
  assign l2_req.tag   = {SRC_EVICT, (L2_TAG_W-1)'(r_rd_ptr)};
  assign l2_req.data  = r_data[r_rd_ptr];

  // No response for writes, the slot is free on transfer
  assign w_sent = l2_req.valid & l2_req.ready;

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      r_vld    <= '0;
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_accept) begin
        r_vld[r_wr_ptr] <= 1'b1;
        r_wr_ptr        <= r_wr_ptr + 1'b1;
      end
      if (w_sent) begin
        r_vld[r_rd_ptr] <= 1'b0;
        r_rd_ptr        <= r_rd_ptr + 1'b1;
      end
    end
  end

  // Slot payload
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_line[r_wr_ptr] <= i_evict_paddr[PADDR_W-1:LINE_OFS_W];
      r_data[r_wr_ptr] <= i_evict_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/l2_req_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module l2_req_arbiter
  import l1d_miss_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  l2_req_if.arbiter              ld_req,
  l2_req_if.arbiter              ev_req,
  output logic                   o_req_valid,
  input  logic                   i_req_ready,
  output l2_cmd_e                o_req_cmd,
  output logic [PADDR_W-1:0]     o_req_addr,
  output logic [L2_TAG_W-1:0]    o_req_tag,
  output logic [LINE_DATA_W-1:0] o_req_data
);

  logic r_last_ev;
  logic r_hold;
  logic r_hold_ev;
  logic w_pick_ev;

  // A stalled grant stays put, otherwise round-robin on a tie
  always_comb begin
    if (r_hold) begin
      w_pick_ev = r_hold_ev;
    end else if (ld_req.valid && ev_req.valid) begin
      w_pick_ev = ~r_last_ev;
    end else begin
      w_pick_ev = ev_req.valid;
    end
  end

  assign o_req_valid = w_pick_ev ? ev_req.valid : ld_req.valid;
  assign o_req_cmd   = w_pick_ev ? ev_req.cmd   : ld_req.cmd;
  assign o_req_addr  = w_pick_ev ? ev_req.addr  : ld_req.addr;
  assign o_req_tag   = w_pick_ev ? ev_req.tag   : ld_req.tag;
  assign o_req_data  = w_pick_ev ? ev_req.data  : ld_req.data;

  assign ld_req.ready = ~w_pick_ev & i_req_ready;
  assign ev_req.ready = w_pick_ev & i_req_ready;

  // Last grant starts on evict so the load side wins the first tie
  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      r_last_ev <= 1'b1;
      r_hold    <= 1'b0;
      r_hold_ev <= 1'b0;
    end else begin
      if (o_req_valid && i_req_ready) begin
        r_last_ev <= w_pick_ev;
      end
      r_hold    <= o_req_valid & ~i_req_ready;
      r_hold_ev <= w_pick_ev;
    end
  end

endmodule

`default_nettype wire

/* rtl/l1d_miss_top.sv */
`timescale 1ns/100ps
`default_nettype none

module l1d_miss_top
  import l1d_miss_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic [LSU_PORT_NUM-1:0] i_ld_valid,
  input  logic [PADDR_W-1:0]      i_ld_paddr [LSU_PORT_NUM],
  output logic [LSU_PORT_NUM-1:0] o_ld_full,
  output logic [LSU_PORT_NUM-1:0] o_ld_conflict,
  output logic [LRQ_ENTRIES-1:0]  o_ld_index_oh [LSU_PORT_NUM],

  input  logic                    i_stq_valid,
  input  logic [PADDR_W-1:0]      i_stq_paddr,
  output logic                    o_stq_full,
  output logic                    o_stq_conflict,

  input  logic                    i_evict_valid,
  input  logic [PADDR_W-1:0]      i_evict_paddr,
  input  logic [LINE_DATA_W-1:0]  i_evict_data,
  output logic                    o_evict_ready,

  output logic                    o_l2_req_valid,
  input  logic                    i_l2_req_ready,
  output l2_cmd_e                 o_l2_req_cmd,
  output logic [PADDR_W-1:0]      o_l2_req_addr,
  output logic [L2_TAG_W-1:0]     o_l2_req_tag,
  output logic [LINE_DATA_W-1:0]  o_l2_req_data,

  input  logic                    i_l2_resp_valid,
  input  logic [L2_TAG_W-1:0]     i_l2_resp_tag,

  output logic                    o_resolve_valid,
  output logic [LRQ_ENTRIES-1:0]  o_resolve_index_oh
);

  l1d_miss_port_if ld_if [LSU_PORT_NUM] ();
  l1d_miss_port_if stq_if ();
  l2_req_if        ld_req_if ();
  l2_req_if        ev_req_if ();

  // ----------------------------------------------------------------------
  // Miss port mapping
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < LSU_PORT_NUM; p++) begin : g_ld_map
    assign ld_if[p].valid   = i_ld_valid[p];
    assign ld_if[p].paddr   = i_ld_paddr[p];
    assign o_ld_full[p]     = ld_if[p].full;
    assign o_ld_conflict[p] = ld_if[p].conflict;
    assign o_ld_index_oh[p] = ld_if[p].hit_index_oh;
  end

  assign stq_if.valid   = i_stq_valid;
  assign stq_if.paddr   = i_stq_paddr;
  assign o_stq_full     = stq_if.full;
  assign o_stq_conflict = stq_if.conflict;

  l1d_load_requester u_load_requester (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .ld_port            (ld_if),
    .stq_port           (stq_if),
    .l2_req             (ld_req_if),
    .i_resp_valid       (i_l2_resp_valid),
    .i_resp_tag         (i_l2_resp_tag),
    .o_resolve_valid    (o_resolve_valid),
    .o_resolve_index_oh (o_resolve_index_oh)
  );

  l1d_evict_buffer u_evict_buffer (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_evict_valid (i_evict_valid),
    .i_evict_paddr (i_evict_paddr),
    .i_evict_data  (i_evict_data),
    .o_evict_ready (o_evict_ready),
    .l2_req        (ev_req_if)
  );

  l2_req_arbiter u_arbiter (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .ld_req      (ld_req_if),
    .ev_req      (ev_req_if),
    .o_req_valid (o_l2_req_valid),
    .i_req_ready (i_l2_req_ready),
    .o_req_cmd   (o_l2_req_cmd),
    .o_req_addr  (o_l2_req_addr),
    .o_req_tag   (o_l2_req_tag),
    .o_req_data  (o_l2_req_data)
  );

endmodule

`default_nettype wire

/* dv/tb_l1d_miss.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_l1d_miss
  import l1d_miss_pkg::*;
();

  localparam int         CLK_PERIOD   = 40;
  localparam int         RESET_CYCLES = 8;
  localparam logic [1:0] RDY_RANDOM   = 2'd2;

  localparam logic [31:0] A_ADDR = 32'h0000_1004;
  localparam logic [31:0] B_ADDR = 32'h0000_2008;
  localparam logic [31:0] C_ADDR = 32'h0000_300c;
  localparam logic [31:0] D_ADDR = 32'h0000_4000;
  localparam logic [31:0] E_ADDR = 32'h0000_5004;
  localparam logic [31:0] F_ADDR = 32'h0000_6008;

  typedef struct packed {
    logic [1:0]  ldv;
    logic [31:0] a0;
    logic [31:0] a1;
    logic        sv;
    logic [31:0] sa;
    logic        ev;
    logic [31:0] ea;
    logic [1:0]  rdy;
    logic        rv;
    logic [3:0]  rt;
    logic [1:0]  xfull;
    logic [1:0]  xconf;
    logic        xsf;
    logic        xsc;
    logic        xres;
    logic [3:0]  xoh;
  } step_t;

  logic                   clk;
  logic                   reset_n;
  logic [1:0]             ld_valid;
  logic [PADDR_W-1:0]     ld_paddr [LSU_PORT_NUM];
  logic [1:0]             ld_full;
  logic [1:0]             ld_conflict;
  logic [LRQ_ENTRIES-1:0] ld_index_oh [LSU_PORT_NUM];
  logic                   stq_valid;
  logic [PADDR_W-1:0]     stq_paddr;
  logic                   stq_full;
  logic                   stq_conflict;
  logic                   evict_valid;
  logic [PADDR_W-1:0]     evict_paddr;
  logic [LINE_DATA_W-1:0] evict_data;
  logic                   evict_ready;
  logic                   req_valid;
  logic                   req_ready;
  l2_cmd_e                req_cmd;
  logic [PADDR_W-1:0]     req_addr;
  logic [L2_TAG_W-1:0]    req_tag;
  logic [LINE_DATA_W-1:0] req_data;
  logic                   resp_valid;
  logic [L2_TAG_W-1:0]    resp_tag;
  logic                   resolve_valid;
  logic [LRQ_ENTRIES-1:0] resolve_oh;

  step_t steps [$];
  string names [$];
  int    errors = 0;
  logic [31:0] lfsr_state = 32'hec813fa0;

  // Reference model of the miss queue, eviction slots and arbiter
  logic                   m_valid [LRQ_ENTRIES];
  logic [LINE_ADDR_W-1:0] m_line [LRQ_ENTRIES];
  int                     m_wr = 0;
  int                     m_ev_wr = 0;
  logic [31:0]            exp_ld_addr [$];
  logic [3:0]             exp_ld_tag [$];
  logic [31:0]            exp_ev_addr [$];
  logic [3:0]             exp_ev_tag [$];
  logic [127:0]           exp_ev_data [$];
  logic                   exp_ev_ready = 1'b1;
  logic                   last_ev = 1'b1;
  logic                   stalled = 1'b0;
  logic [164:0]           held_req;

  l1d_miss_top dut0 (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_ld_valid (ld_valid), .i_ld_paddr (ld_paddr), .o_ld_full (ld_full),
    .o_ld_conflict (ld_conflict), .o_ld_index_oh (ld_index_oh),
    .i_stq_valid (stq_valid), .i_stq_paddr (stq_paddr),
    .o_stq_full (stq_full), .o_stq_conflict (stq_conflict),
    .i_evict_valid (evict_valid), .i_evict_paddr (evict_paddr),
    .i_evict_data (evict_data), .o_evict_ready (evict_ready),
    .o_l2_req_valid (req_valid), .i_l2_req_ready (req_ready),
    .o_l2_req_cmd (req_cmd), .o_l2_req_addr (req_addr),
    .o_l2_req_tag (req_tag), .o_l2_req_data (req_data),
    .i_l2_resp_valid (resp_valid), .i_l2_resp_tag (resp_tag),
    .o_resolve_valid (resolve_valid), .o_resolve_index_oh (resolve_oh)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [127:0] line_data(input logic [31:0] addr);
    return {addr, ~addr, addr ^ 32'h5a5a_a5a5, ~addr ^ 32'h0f0f_f0f0};
  endfunction

  function automatic logic [3:0] model_hit_oh(input logic [31:0] addr);
    logic [3:0] oh;
    oh = '0;
    for (int b = 0; b < LRQ_ENTRIES; b++) begin
      oh[b] = m_valid[b] && (m_line[b] == addr[31:4]);
    end
    return oh;
  endfunction

  task automatic add_step(input string name, input logic [1:0] ldv, input logic [31:0] a0,
                          input logic [31:0] a1, input logic sv, input logic [31:0] sa,
                          input logic ev, input logic [31:0] ea, input logic [1:0] rdy,
                          input logic rv, input logic [3:0] rt, input logic [1:0] xfull,
                          input logic [1:0] xconf, input logic xsf, input logic xsc,
                          input logic xres, input logic [3:0] xoh);
    step_t s;
    s = '{ldv, a0, a1, sv, sa, ev, ea, rdy, rv, rt, xfull, xconf, xsf, xsc, xres, xoh};
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic drive_step(input step_t s);
    ld_valid    <= s.ldv;
    ld_paddr[0] <= s.a0;
    ld_paddr[1] <= s.a1;
    stq_valid   <= s.sv;
    stq_paddr   <= s.sa;
    evict_valid <= s.ev;
    evict_paddr <= s.ea;
    evict_data  <= line_data(s.ea);
    resp_valid  <= s.rv;
    resp_tag    <= s.rt;
    if (s.rdy == RDY_RANDOM) begin
      lfsr_state = lfsr_next(lfsr_state);
      req_ready <= lfsr_state[0];
    end else begin
      req_ready <= s.rdy[0];
    end
  endtask

  // Sampled mid-cycle; a transfer happens at the following rising edge
  task automatic check_bus(input string name);
    logic is_ev;
    logic [164:0] cur;
    cur = {req_cmd, req_addr, req_tag, req_data};
    if (stalled) begin
      assert (req_valid && cur == held_req) else begin
        errors++;
        $display("%s: a stalled L2 request was dropped or changed", name);
      end
    end
    if (exp_ld_addr.size() != 0 || exp_ev_addr.size() != 0) begin
      assert (req_valid) else begin
        errors++;
        $display("%s: a pending request is missing from the L2 bus", name);
      end
    end
    if (req_valid) begin
      is_ev = (req_cmd == CMD_WRITE);
      if (!stalled && exp_ld_addr.size() != 0 && exp_ev_addr.size() != 0) begin
        check_val({name, " grant"}, !last_ev, is_ev);
      end
      if (req_ready) begin
        if (is_ev && exp_ev_addr.size() != 0) begin
          check_val({name, " write addr"}, exp_ev_addr.pop_front(), req_addr);
          check_val({name, " write tag"}, exp_ev_tag.pop_front(), req_tag);
          check_val({name, " write data"}, exp_ev_data.pop_front(), req_data);
        end else if (!is_ev && exp_ld_addr.size() != 0) begin
          check_val({name, " read addr"}, exp_ld_addr.pop_front(), req_addr);
          check_val({name, " read tag"}, exp_ld_tag.pop_front(), req_tag);
        end else begin
          errors++;
          $display("%s: an unexpected request transferred on the L2 bus", name);
        end
        last_ev = is_ev;
        stalled = 1'b0;
      end else begin
        stalled  = 1'b1;
        held_req = cur;
      end
    end else begin
      stalled = 1'b0;
    end
  endtask

  task automatic update_model(input step_t s);
    logic [31:0] addr;
    int cnt;
    int tgt;
    cnt = 0;
    for (int p = 0; p < LSU_PORT_NUM; p++) begin
      addr = (p == 0) ? s.a0 : s.a1;
      tgt  = (m_wr + cnt) % LRQ_ENTRIES;
      if (s.ldv[p] && model_hit_oh(addr) == 0 && !m_valid[tgt] &&
          !(p == 1 && s.ldv[0] && s.a0[31:4] == s.a1[31:4])) begin
        m_valid[tgt] = 1'b1;
        m_line[tgt]  = addr[31:4];
        exp_ld_addr.push_back({addr[31:4], 4'h0});
        exp_ld_tag.push_back({SRC_LOAD, 3'(tgt)});
        cnt++;
      end
    end
    if (s.sv && cnt == 0 && model_hit_oh(s.sa) == 0 && !m_valid[m_wr]) begin
      m_valid[m_wr] = 1'b1;
      m_line[m_wr]  = s.sa[31:4];
      exp_ld_addr.push_back({s.sa[31:4], 4'h0});
      exp_ld_tag.push_back({SRC_LOAD, 3'(m_wr)});
      cnt++;
    end
    m_wr = (m_wr + cnt) % LRQ_ENTRIES;
    if (s.rv && s.rt[3] == SRC_LOAD) begin
      m_valid[s.rt[1:0]] = 1'b0;
    end
    if (s.ev && exp_ev_ready) begin
      exp_ev_addr.push_back({s.ea[31:4], 4'h0});
      exp_ev_tag.push_back({SRC_EVICT, 3'(m_ev_wr)});
      exp_ev_data.push_back(line_data(s.ea));
      m_ev_wr = (m_ev_wr + 1) % EVB_ENTRIES;
    end
  endtask

  task automatic check_step(input string name, input step_t s);
    // A slot is free while fewer writes are pending than there are slots
    exp_ev_ready = (exp_ev_addr.size() < EVB_ENTRIES);
    check_val({name, " evict ready"}, exp_ev_ready, evict_ready);
    for (int p = 0; p < LSU_PORT_NUM; p++) begin
      assert ($onehot0(ld_index_oh[p])) else begin
        errors++;
        $display("%s: hit_index_oh of port %0d is not one-hot", name, p);
      end
      if (s.ldv[p]) begin
        check_val($sformatf("%s full%0d", name, p), s.xfull[p], ld_full[p]);
        check_val($sformatf("%s conflict%0d", name, p), s.xconf[p], ld_conflict[p]);
        check_val($sformatf("%s hit_oh%0d", name, p),
                  model_hit_oh(p == 0 ? s.a0 : s.a1), ld_index_oh[p]);
      end
    end
    if (s.sv) begin
      check_val({name, " stq full"}, s.xsf, stq_full);
      check_val({name, " stq conflict"}, s.xsc, stq_conflict);
    end
    check_val({name, " resolve"}, s.xres, resolve_valid);
    check_val({name, " resolve oh"}, s.xoh, resolve_oh);
  endtask

  // --------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------
  task automatic build_table();
    add_step("new_line", 2'b01, A_ADDR, 0, 0, 0, 1, 32'h0000_b10c, 1, 0, 0,
             2'b00, 2'b00, 0, 0, 0, 0);
    add_step("conflict", 2'b11, A_ADDR, B_ADDR, 0, 0, 0, 0, 1, 0, 0, 2'b00, 2'b01, 0, 0, 0, 0);
    add_step("same_line", 2'b11, C_ADDR, 32'h0000_3000, 0, 0, 0, 0, 1, 0, 0,
             2'b00, 2'b00, 0, 0, 0, 0);
    add_step("fill", 2'b01, D_ADDR, 0, 0, 0, 0, 0, 1, 0, 0, 2'b00, 2'b00, 0, 0, 0, 0);
    add_step("full_ld", 2'b11, E_ADDR, A_ADDR, 0, 0, 0, 0, 1, 0, 0, 2'b11, 2'b10, 0, 0, 0, 0);
    add_step("full_stq", 2'b00, 0, 0, 1, F_ADDR, 0, 0, 1, 0, 0, 2'b00, 2'b00, 1, 0, 0, 0);
    add_step("stq_conflict", 2'b00, 0, 0, 1, B_ADDR, 0, 0, 1, 0, 0, 2'b00, 2'b00, 1, 1, 0, 0);
    add_step("refill0", 2'b00, 0, 0, 0, 0, 0, 0, 1, 1, 4'h0, 2'b00, 2'b00, 0, 0, 0, 0);
    add_step("resolve0", 2'b01, E_ADDR, 0, 0, 0, 0, 0, 1, 0, 0, 2'b00, 2'b00, 0, 0, 1, 4'b0001);
    add_step("refill1", 2'b01, B_ADDR, 0, 0, 0, 0, 0, 1, 1, 4'h1, 2'b01, 2'b01, 0, 0, 0, 0);
    add_step("resolve1", 2'b00, 0, 0, 1, F_ADDR, 0, 0, 1, 0, 0, 2'b00, 2'b00, 0, 0, 1, 4'b0010);
    add_step("refill2", 2'b00, 0, 0, 0, 0, 0, 0, 1, 1, 4'h2, 2'b00, 2'b00, 0, 0, 0, 0);
    add_step("refill3", 2'b00, 0, 0, 0, 0, 0, 0, 1, 1, 4'h3, 2'b00, 2'b00, 0, 0, 1, 4'b0100);
    add_step("resolve3", 2'b00, 0, 0, 0, 0, 0, 0, 1, 0, 0, 2'b00, 2'b00, 0, 0, 1, 4'b1000);
    add_step("evict_load", 2'b01, 32'h0000_8000, 0, 0, 0, 1, 32'h0000_7004, 0, 0, 0,
             2'b00, 2'b00, 0, 0, 0, 0);
    add_step("evict_tie", 2'b01, 32'h0000_a000, 0, 0, 0, 1, 32'h0000_9008, 0, 0, 0,
             2'b00, 2'b00, 0, 0, 0, 0);
    add_step("alternate", 2'b00, 0, 0, 0, 0, 0, 0, 1, 0, 0, 2'b00, 2'b00, 0, 0, 0, 0);
    add_step("refill_e", 2'b00, 0, 0, 0, 0, 0, 0, 1, 1, 4'h0, 2'b00, 2'b00, 0, 0, 0, 0);
    add_step("refill_f", 2'b00, 0, 0, 0, 0, 0, 0, 1, 1, 4'h1, 2'b00, 2'b00, 0, 0, 1, 4'b0001);
    add_step("rand_load", 2'b01, 32'h0000_c000, 0, 0, 0, 1, 32'h0000_d00c, RDY_RANDOM, 0, 0,
             2'b00, 2'b00, 0, 0, 1, 4'b0010);
    add_step("rand_pair", 2'b11, 32'h0000_e000, 32'h0000_f000, 0, 0, 0, 0, RDY_RANDOM, 0, 0,
             2'b10, 2'b00, 0, 0, 0, 0);
    add_step("rand_stq", 2'b00, 0, 0, 1, 32'h0000_c008, 0, 0, RDY_RANDOM, 0, 0,
             2'b00, 2'b00, 1, 1, 0, 0);
    add_step("rand_evict", 2'b00, 0, 0, 0, 0, 1, 32'h0000_b000, RDY_RANDOM, 0, 0,
             2'b00, 2'b00, 0, 0, 0, 0);
    add_step("rand_idle", 2'b00, 0, 0, 0, 0, 0, 0, RDY_RANDOM, 0, 0, 2'b00, 2'b00, 0, 0, 0, 0);
    add_step("rand_idle", 2'b00, 0, 0, 0, 0, 0, 0, RDY_RANDOM, 0, 0, 2'b00, 2'b00, 0, 0, 0, 0);
  endtask

  initial begin
    step_t idle;
    reset_n     = 1'b1;
    ld_valid    = '0;
    ld_paddr[0] = '0;
    ld_paddr[1] = '0;
    stq_valid   = 1'b0;
    stq_paddr   = '0;
    evict_valid = 1'b0;
    evict_paddr = '0;
    evict_data  = '0;
    req_ready   = 1'b0;
    resp_valid  = 1'b0;
    resp_tag    = '0;
    for (int b = 0; b < LRQ_ENTRIES; b++) begin
      m_valid[b] = 1'b0;
      m_line[b]  = '0;
    end
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b0;
    @(negedge clk);
    check_val("reset req_valid", 1'b0, req_valid);
    check_val("reset evict_ready", 1'b1, evict_ready);
    check_val("reset resolve_valid", 1'b0, resolve_valid);
    check_val("reset ld_full", 2'b00, ld_full);
    check_val("reset ld_conflict", 2'b00, ld_conflict);
    check_val("reset stq_full", 1'b0, stq_full);
    check_val("reset stq_conflict", 1'b0, stq_conflict);
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge clk);
      drive_step(steps[i]);
      @(negedge clk);
      check_step(names[i], steps[i]);
      check_bus(names[i]);
      update_model(steps[i]);
    end
    // Drain the remaining requests under random ready
    idle = '0;
    idle.rdy = RDY_RANDOM;
    while (exp_ld_addr.size() != 0 || exp_ev_addr.size() != 0 || stalled) begin
      @(posedge clk);
      drive_step(idle);
      @(negedge clk);
      check_bus("drain");
    end
    // Bus must go quiet once the last request has left
    @(negedge clk);
    check_val("drain idle", 1'b0, req_valid);
    $display("Run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (RESET_CYCLES + steps.size() * 20) @(posedge clk);
    $display("Timeout: the L2 request bus did not drain in time");
    $display("Run complete, %0d errors", errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/l1d_miss_pkg.sv
rtl/l1d_miss_port_if.sv
rtl/l2_req_if.sv
rtl/l1d_load_requester.sv
rtl/l1d_evict_buffer.sv
rtl/l2_req_arbiter.sv
rtl/l1d_miss_top.sv
dv/tb_l1d_miss.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_l1d_miss \
  -f sources.f -Mdir obj_dir &&
./obj_dir/Vtb_l1d_miss | grep -x "NO ERRORS" &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }
